//--- hw/hc_chan_pkg.sv
//==========================================================================
// Host channel definitions
// Widths of the cache-line address, the line payload and the read tag
// that a request carries and its response returns
//==========================================================================

`default_nettype none

package hc_chan_pkg;

    //==========================================================================
    // Line addressing and payload
    //==========================================================================

    // Host memory is addressed in whole cache lines
    localparam int line_addr_w = 32;

    // One line of data, kept narrow so simulation stays quick
    localparam int line_data_w = 64;

    // Read tag width
    // The tag is used directly as the reorder slot index
    localparam int tag_w = 3;

endpackage

`default_nettype wire

//--- hw/hc_ring_pkg.sv
//==========================================================================
// Ring-buffer definitions
// Ring index width, reorder depth and the configuration register map
//==========================================================================

`default_nettype none

package hc_ring_pkg;

    // 16-line ring, so pointers wrap on their own at the top of the range
    localparam int ring_idx_w = 4;

    // One reorder slot per tag value
    localparam int rob_entries = 2 ** hc_chan_pkg::tag_w;

    // Configuration map, one bit of address selects between two registers
    localparam int cfg_addr_w = 1;
    localparam logic [cfg_addr_w-1:0] cfg_base_reg = 1'b0;
    localparam logic [cfg_addr_w-1:0] cfg_newest_reg = 1'b1;

endpackage

`default_nettype wire

//--- hw/hc_ring_cfg.sv
//==========================================================================
// Ring configuration registers
// Holds the ring base line address and the newest published index,
// both loaded by a single-cycle host write strobe
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module hc_ring_cfg
(
    input  logic                                   clk,
    input  logic                                   resetb,
    input  logic                                   cfg_wr,
    input  logic [hc_ring_pkg::cfg_addr_w-1:0]     cfg_addr,
    input  logic [hc_chan_pkg::line_addr_w-1:0]    cfg_wdata,
    output logic [hc_chan_pkg::line_addr_w-1:0]    base_addr,
    output logic [hc_ring_pkg::ring_idx_w-1:0]     newest_idx
);

    // The host publishes the base once and then moves the newest index
    // forward as it writes lines into the ring
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            base_addr  <= '0;
            newest_idx <= '0;
        end
        else if (cfg_wr)
        begin
            // New values reach the reader in the cycle after the strobe
            if (cfg_addr == hc_ring_pkg::cfg_base_reg)
            begin
                base_addr <= cfg_wdata;
            end
            if (cfg_addr == hc_ring_pkg::cfg_newest_reg)
            begin
                // Only the low bits of the write form a ring index
                newest_idx <= cfg_wdata[hc_ring_pkg::ring_idx_w-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/hc_rob.sv
//==========================================================================
// Reorder buffer
// Slots are allocated in request order, filled by tag in any order and
// released in request order once the oldest slot holds its line
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module hc_rob
(
    input  logic                                 clk,
    input  logic                                 resetb,
    input  logic                                 alloc,
    input  logic                                 fill,
    input  logic [hc_chan_pkg::tag_w-1:0]        fill_tag,
    input  logic [hc_chan_pkg::line_data_w-1:0]  fill_data,
    input  logic                                 release_en,
    output logic                                 slot_free,
    output logic [hc_chan_pkg::tag_w-1:0]        alloc_tag,
    output logic                                 head_filled,
    output logic [hc_chan_pkg::line_data_w-1:0]  head_data
);

    // Pointers carry one extra bit so a full buffer differs from an empty one
    logic [hc_chan_pkg::tag_w:0]               alloc_ptr;
    logic [hc_chan_pkg::tag_w:0]               rel_ptr;
    logic [hc_chan_pkg::tag_w:0]               in_flight;
    logic [hc_chan_pkg::tag_w-1:0]             head_idx;
    logic [hc_ring_pkg::rob_entries-1:0]       filled;
    logic [hc_chan_pkg::line_data_w-1:0]       data_q [hc_ring_pkg::rob_entries];

    //==========================================================================
    // Slot status
    //==========================================================================

    assign in_flight = alloc_ptr - rel_ptr;
    assign slot_free = (in_flight < hc_ring_pkg::rob_entries);

    // The tag handed out with a request is the slot it will land in
    assign alloc_tag = alloc_ptr[hc_chan_pkg::tag_w-1:0];
    assign head_idx  = rel_ptr[hc_chan_pkg::tag_w-1:0];

    // An empty head slot always has its flag clear, so no extra occupancy term
    assign head_filled = filled[head_idx];
    assign head_data   = data_q[head_idx];

    //==========================================================================
    // Pointers and fill flags
    //==========================================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            alloc_ptr <= '0;
            rel_ptr   <= '0;
            filled    <= '0;
        end
        else
        begin
            if (alloc)
            begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
            // A response always targets an allocated, unfilled slot, while a
            // release targets the filled head, so the two never collide
            if (fill)
            begin
                filled[fill_tag] <= 1'b1;
            end
            if (release_en)
            begin
                filled[head_idx] <= 1'b0;
                rel_ptr          <= rel_ptr + 1'b1;
            end
        end
    end

    // Line storage, written as responses arrive
    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            data_q[fill_tag] <= fill_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/hc_fifo2.sv
//==========================================================================
// Two-entry output queue
// Register-based queue with a registered head word, so the client path
// has no combinational route back into the reorder buffer
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module hc_fifo2
(
    input  logic                                 clk,
    input  logic                                 resetb,
    input  logic                                 enq_en,
    input  logic [hc_chan_pkg::line_data_w-1:0]  enq_data,
    input  logic                                 deq_en,
    output logic                                 not_full,
    output logic                                 not_empty,
    output logic [hc_chan_pkg::line_data_w-1:0]  first
);

    logic                                 tail_valid;
    logic [hc_chan_pkg::line_data_w-1:0]  tail_data;

    assign not_full = !tail_valid;

    // Occupancy: the head fills first, the tail only holds a second word
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            not_empty  <= 1'b0;
            tail_valid <= 1'b0;
        end
        else if (deq_en)
        begin
            // The tail moves up, or a new word takes the empty head
            not_empty  <= tail_valid || enq_en;
            tail_valid <= tail_valid && enq_en;
        end
        else if (enq_en)
        begin
            not_empty  <= 1'b1;
            tail_valid <= not_empty;
        end
    end

    // Payload moves with the occupancy flags above
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            first     <= tail_valid ? tail_data : enq_data;
            tail_data <= enq_data;
        end
        else if (enq_en)
        begin
            if (not_empty)
            begin
                tail_data <= enq_data;
            end
            else
            begin
                first <= enq_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/hc_ring_reader.sv
//==========================================================================
// Ring reader
// Walks the ring from the next unread line up to the newest published
// index, issues one line read per cycle while reorder slots are free and
// tracks the oldest line still held by the FPGA side
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module hc_ring_reader
(
    input  logic                                 clk,
    input  logic                                 resetb,
    input  logic [hc_chan_pkg::line_addr_w-1:0]  base_addr,
    input  logic [hc_ring_pkg::ring_idx_w-1:0]   newest_idx,
    input  logic                                 slot_free,
    input  logic [hc_chan_pkg::tag_w-1:0]        alloc_tag,
    input  logic                                 head_filled,
    input  logic                                 queue_not_full,
    output logic                                 rd_req,
    output logic [hc_chan_pkg::line_addr_w-1:0]  rd_addr,
    output logic [hc_chan_pkg::tag_w-1:0]        rd_tag,
    output logic                                 release_en,
    output logic [hc_ring_pkg::ring_idx_w-1:0]   oldest_idx
);

    // Ring index of the next line to request
    logic [hc_ring_pkg::ring_idx_w-1:0]  next_req_idx;

    //==========================================================================
    // Read request generation
    //==========================================================================

    // Unread lines exist while the request pointer trails the newest index.
    // The host takes every strobe, so a request here is also an allocation
    assign rd_req = (next_req_idx != newest_idx) && slot_free;

    // The index is added to the base rather than dropped into its low bits,
    // so the ring may start on any line.
    // The ring size must still be a power of two for the pointers to wrap
    assign rd_addr = base_addr + hc_chan_pkg::line_addr_w'(next_req_idx);

    // The response will come back into the slot allocated this cycle
    assign rd_tag = alloc_tag;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            next_req_idx <= '0;
        end
        else if (rd_req)
        begin
            next_req_idx <= next_req_idx + 1'b1;
        end
    end

    //==========================================================================
    // Release and oldest-line tracking
    //==========================================================================

    // Lines leave the reorder buffer in request order whenever the head
    // holds data and the output queue can take it
    assign release_en = head_filled && queue_not_full;

    // The oldest pointer moves as lines leave the reorder buffer, not as
    // responses arrive.
    // Out-of-order arrivals never have to be tracked this way
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            oldest_idx <= '0;
        end
        else if (release_en)
        begin
            // The host may now reuse this ring slot
            oldest_idx <= oldest_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/hc_ring_top.sv
//==========================================================================
// Ring-buffer reader top level
// Connects the configuration registers, the ring reader, the reorder
// buffer and the two-entry output queue facing the client
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module hc_ring_top
(
    input  logic                                 clk,
    input  logic                                 resetb,
    input  logic                                 cfg_wr,
    input  logic [hc_ring_pkg::cfg_addr_w-1:0]   cfg_addr,
    input  logic [hc_chan_pkg::line_addr_w-1:0]  cfg_wdata,
    input  logic                                 rsp_valid,
    input  logic [hc_chan_pkg::tag_w-1:0]        rsp_tag,
    input  logic [hc_chan_pkg::line_data_w-1:0]  rsp_data,
    input  logic                                 rx_enable,
    output logic                                 rd_req,
    output logic [hc_chan_pkg::line_addr_w-1:0]  rd_addr,
    output logic [hc_chan_pkg::tag_w-1:0]        rd_tag,
    output logic [hc_chan_pkg::line_data_w-1:0]  rx_data,
    output logic                                 rx_rdy,
    output logic [hc_ring_pkg::ring_idx_w-1:0]   oldest_idx
);

    logic [hc_chan_pkg::line_addr_w-1:0]  base_addr;
    logic [hc_ring_pkg::ring_idx_w-1:0]   newest_idx;
    logic                                 slot_free;
    logic [hc_chan_pkg::tag_w-1:0]        alloc_tag;
    logic                                 head_filled;
    logic [hc_chan_pkg::line_data_w-1:0]  head_data;
    logic                                 release_en;
    logic                                 queue_not_full;

    hc_ring_cfg u_cfg
    (
        .clk        (clk),
        .resetb     (resetb),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .base_addr  (base_addr),
        .newest_idx (newest_idx)
    );

    hc_ring_reader u_reader
    (
        .clk            (clk),
        .resetb         (resetb),
        .base_addr      (base_addr),
        .newest_idx     (newest_idx),
        .slot_free      (slot_free),
        .alloc_tag      (alloc_tag),
        .head_filled    (head_filled),
        .queue_not_full (queue_not_full),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_tag         (rd_tag),
        .release_en     (release_en),
        .oldest_idx     (oldest_idx)
    );

    // Every accepted request claims the next reorder slot
    hc_rob u_rob
    (
        .clk         (clk),
        .resetb      (resetb),
        .alloc       (rd_req),
        .fill        (rsp_valid),
        .fill_tag    (rsp_tag),
        .fill_data   (rsp_data),
        .release_en  (release_en),
        .slot_free   (slot_free),
        .alloc_tag   (alloc_tag),
        .head_filled (head_filled),
        .head_data   (head_data)
    );

    // The client drains the queue with its own ready/enable pair
    hc_fifo2 u_out_q
    (
        .clk       (clk),
        .resetb    (resetb),
        .enq_en    (release_en),
        .enq_data  (head_data),
        .deq_en    (rx_enable),
        .not_full  (queue_not_full),
        .not_empty (rx_rdy),
        .first     (rx_data)
    );

endmodule

`default_nettype wire

//--- tb/hc_ring_checker.sv
//==========================================================================
// Ring reader protocol checker
// Concurrent assertions on read request issue, reorder occupancy and
// the client-facing output hold rule
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module hc_ring_checker
(
    input  wire logic                                 clk,
    input  wire logic                                 resetb,
    input  wire logic                                 rd_req,
    input  wire logic [hc_ring_pkg::ring_idx_w-1:0]   newest_idx,
    input  wire logic                                 release_en,
    input  wire logic                                 rx_rdy,
    input  wire logic                                 rx_enable,
    input  wire logic [hc_chan_pkg::line_data_w-1:0]  rx_data
);

    // Lines requested but not yet released from the reorder buffer
    logic [hc_chan_pkg::tag_w+1:0]        in_rob;

    // Ring index of the next request, counted from the request strobes alone
    logic [hc_ring_pkg::ring_idx_w-1:0]   req_idx;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            in_rob  <= '0;
            req_idx <= '0;
        end
        else
        begin
            in_rob <= in_rob + (hc_chan_pkg::tag_w+2)'(rd_req)
                      - (hc_chan_pkg::tag_w+2)'(release_en);
            if (rd_req)
            begin
                req_idx <= req_idx + 1'b1;
            end
        end
    end

    // A request is only legal while unread lines remain
    assert property (@(posedge clk) disable iff (!resetb)
        rd_req |-> (req_idx != newest_idx))
        else $error("read request with no unread line");

    assert property (@(posedge clk) disable iff (!resetb)
        in_rob <= hc_ring_pkg::rob_entries)
        else $error("more lines in flight than reorder slots");

    // A word offered to the client holds until it is taken
    assert property (@(posedge clk) disable iff (!resetb)
        (rx_rdy && !rx_enable) |=> (rx_rdy && $stable(rx_data)))
        else $error("output word changed before it was consumed");

endmodule

bind hc_ring_top hc_ring_checker u_checker
(
    .clk          (clk),
    .resetb       (resetb),
    .rd_req       (rd_req),
    .newest_idx   (newest_idx),
    .release_en   (release_en),
    .rx_rdy       (rx_rdy),
    .rx_enable    (rx_enable),
    .rx_data      (rx_data)
);

`default_nettype wire

//--- tb/hc_ring_tb.sv
//==========================================================================
// Ring-buffer reader testbench
// Host memory model with an out-of-order responder, a client that drains
// the output queue, and directed tests for flow, back-pressure and wrap
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module hc_ring_tb;

    localparam int total_lines = 77;
    logic clk, resetb, cfg_wr, rsp_valid, rx_enable, rd_req, rx_rdy;
    logic [hc_ring_pkg::cfg_addr_w-1:0] cfg_addr;
    logic [31:0] cfg_wdata, rd_addr, cur_base;
    logic [hc_chan_pkg::tag_w-1:0] rsp_tag, rd_tag;
    logic [63:0] rsp_data, rx_data;
    logic [3:0] oldest_idx;
    int req_total, rx_total, pub_total, cycle;
    bit ooo, consume_on;
    int pend_tag[$], pend_due[$];
    logic [31:0] pend_addr[$];

    hc_ring_top u_dut (.clk(clk), .resetb(resetb), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .rsp_valid(rsp_valid), .rsp_tag(rsp_tag), .rsp_data(rsp_data),
        .rx_enable(rx_enable), .rd_req(rd_req), .rd_addr(rd_addr), .rd_tag(rd_tag),
        .rx_data(rx_data), .rx_rdy(rx_rdy), .oldest_idx(oldest_idx));

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ends the run with the fail message
    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Host memory content, a fixed scramble of the line address
    function automatic logic [63:0] line_word(logic [31:0] a);
        return {a ^ 32'h5a5a_c3c3, (a * 32'h9e37_79b9) ^ 32'h0f0f_1234};
    endfunction

    // Line k since reset sits at ring index k modulo 16
    function automatic logic [31:0] line_addr(int k);
        return cur_base + 32'(k % 16);
    endfunction

    // Responder: records each request at the falling edge, answers later
    initial
    begin : responder
        int pick;
        forever
        begin
            @(negedge clk);
            if (resetb && rd_req)
            begin
                if (req_total >= pub_total)
                begin
                    $display("Read request issued past the newest published index");
                    stop_run();
                end
                check("rd_addr", rd_addr, line_addr(req_total));
                check("rd_tag", rd_tag, req_total % 8);
                pend_tag.push_back(rd_tag);
                pend_addr.push_back(rd_addr);
                pend_due.push_back(cycle + 1 + (ooo ? int'($urandom % 8) : 0));
                req_total++;
            end
            @(posedge clk);
            #10;
            cycle++;
            rsp_valid = 1'b0;
            pick = -1;
            // First request whose delay has run out, so random delays reorder
            foreach (pend_due[i])
            begin
                if (pick < 0 && pend_due[i] <= cycle)
                    pick = i;
            end
            if (pick >= 0)
            begin
                rsp_valid = 1'b1;
                rsp_tag = pend_tag[pick];
                rsp_data = line_word(pend_addr[pick]);
                pend_tag.delete(pick);
                pend_addr.delete(pick);
                pend_due.delete(pick);
            end
        end
    end

    // Client: takes a word seen at the falling edge with a pulse after the next rise
    initial
    begin : consumer
        logic take;
        take = 1'b0;
        forever
        begin
            @(posedge clk);
            #10;
            rx_enable = take;
            @(negedge clk);
            take = resetb && consume_on && rx_rdy && !rx_enable;
            if (take)
            begin
                check("rx_data", rx_data, line_word(line_addr(rx_total)));
                rx_total++;
            end
        end
    end

    task automatic cfg_write(logic [hc_ring_pkg::cfg_addr_w-1:0] addr, logic [31:0] data);
        @(posedge clk);
        #10;
        cfg_wr = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(posedge clk);
        #10;
        cfg_wr = 1'b0;
    endtask

    task automatic publish(int n);
        pub_total += n;
        cfg_write(hc_ring_pkg::cfg_newest_reg, 32'(pub_total % 16));
    endtask

    // Waits until every published line has reached the client
    task automatic drain();
        while (rx_total < pub_total)
            @(negedge clk);
        repeat (2) @(negedge clk);
        check("req_count", req_total, pub_total);
        check("oldest_idx", oldest_idx, pub_total % 16);
        check("rx_rdy", rx_rdy, 0);
    endtask

    task automatic reset_state();
        @(negedge clk);
        check("rd_req", rd_req, 0);
        check("rx_rdy", rx_rdy, 0);
        check("oldest_idx", oldest_idx, 0);
    endtask

    task automatic in_order_flow();
        ooo = 1'b0;
        cur_base = 32'h0000_1000;
        cfg_write(hc_ring_pkg::cfg_base_reg, cur_base);
        publish(10);
        drain();
    endtask

    task automatic out_of_order_flow();
        ooo = 1'b1;
        publish(12);
        drain();
    endtask

    // Eight reorder slots plus two queue entries stall the reader
    task automatic back_pressure();
        int start_req;
        start_req = req_total;
        consume_on = 1'b0;
        publish(15);
        repeat (40) @(negedge clk);
        check("req_count", req_total - start_req, 10);
        check("rx_rdy", rx_rdy, 1);
        consume_on = 1'b1;
        drain();
    endtask

    task automatic wrap_unaligned();
        cur_base = 32'h0000_2345;
        cfg_write(hc_ring_pkg::cfg_base_reg, cur_base);
        publish(13);
        drain();
        publish(14);
        drain();
        publish(13);
        drain();
    endtask

    // Watchdog sized from the line count with a per-line cycle bound
    initial
    begin
        repeat (total_lines * 40 + 200) @(posedge clk);
        $display("Timeout, the lines were not all delivered in time");
        stop_run();
    end

    initial
    begin
        void'($urandom(32'h5308));
        {resetb, cfg_wr, cfg_addr, cfg_wdata, rsp_valid, rsp_tag, rsp_data, rx_enable} = '0;
        {req_total, rx_total, pub_total, cycle} = '0;
        {ooo, consume_on} = 2'b01;
        cur_base = '0;
        repeat (4) @(posedge clk);
        #10;
        resetb = 1'b1;
        reset_state();
        in_order_flow();
        out_of_order_flow();
        back_pressure();
        wrap_unaligned();
        if (req_total == total_lines && rx_total == total_lines)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            $display("Line count at the end of the run does not match the published lines");
            stop_run();
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/hc_chan_pkg.sv
hw/hc_ring_pkg.sv
hw/hc_ring_cfg.sv
hw/hc_rob.sv
hw/hc_fifo2.sv
hw/hc_ring_reader.sv
hw/hc_ring_top.sv
tb/hc_ring_checker.sv
tb/hc_ring_tb.sv

//--- Bender.yml
package:
  name: hc_ring

sources:
  - hw/hc_chan_pkg.sv
  - hw/hc_ring_pkg.sv
  - hw/hc_ring_cfg.sv
  - hw/hc_rob.sv
  - hw/hc_fifo2.sv
  - hw/hc_ring_reader.sv
  - hw/hc_ring_top.sv
  - target: test
    files:
      - tb/hc_ring_checker.sv
      - tb/hc_ring_tb.sv
